// ==== compile.f ====
rtl/fetch_pkg.sv
rtl/branch_predictor.sv
rtl/insn_queue.sv
rtl/fetch_ctrl.sv
rtl/fetch_frontend.sv
testbench/fetch_mem_model.sv
testbench/fetch_tb.sv

// ==== Makefile ====
# Verilator build and run of the fetch front end testbench

OBJ_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module fetch_tb \
		-Mdir $(OBJ_DIR) -o fetch_sim

run: compile
	./$(OBJ_DIR)/fetch_sim | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// ==== testbench/fetch_tb.sv ====
/*
   Fetch front end testbench
   Drives flushes and BTB updates, pops at random and checks every popped
   instruction against a reference model of the fetch stream
*/
`timescale 1ns/1ns

module fetch_tb;
   import fetch_pkg::*;

   localparam int TIMEOUT = 5000;

   logic                                clk;
   logic                                rst_n;
   logic                                flush;
   pc_t                                 flush_pc;
   logic                                imem_req_valid;
   logic                                imem_req_ready;
   logic [PC_W-1:0]                     imem_req_addr;
   logic                                imem_rsp_valid;
   logic [WIN_W-1:0]                    imem_rsp_data;
   logic                                btb_upd_valid;
   pc_t                                 btb_upd_pc;
   pc_t                                 btb_upd_target;
   logic                                btb_upd_taken;
   logic [FETCH_SLOTS-1:0]              id_valid;
   pc_t [FETCH_SLOTS-1:0]               id_pc;
   logic [FETCH_SLOTS-1:0][INSN_W-1:0]  id_ins;
   logic [FETCH_SLOTS-1:0]              id_pred_taken;
   slot_cnt_t                           id_pop_cnt;

   // BTB mirror, indexed by address bits 5..2
   logic                  mirror_valid [BTB_ENTRIES];
   logic [BTB_TAG_W-1:0]  mirror_tag   [BTB_ENTRIES];
   pc_t                   mirror_tgt   [BTB_ENTRIES];
   pc_t                   exp_pc       [$];
   logic [INSN_W-1:0]     exp_ins      [$];
   logic                  exp_tk       [$];
   logic                  pop_en;
   logic                  hung;
   pc_t                   flush_target;
   string                 test_name;
   int                    mismatches;
   int                    failures;
   int                    checked;

   fetch_frontend dut0 (.*);

   fetch_mem_model mem0 (.*);

   always #4 clk = ~clk;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [INSN_W-1:0] insn_word(input logic [PC_W-1:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h1357_9bdf;
   endfunction

   // Appends the next count instructions fetched from start
   function automatic void expect_stream(input pc_t start, input int count);
      pc_t         cur;
      pc_t         base;
      pc_t         nxt;
      pc_t         p;
      logic [3:0]  idx;
      logic        hit;
      logic        stop;
      int          left;
      cur  = start;
      left = count;
      while (left > 0)
      begin
         base.raw = {cur.f.win, 3'b000};
         nxt.raw  = base.raw + 32'd8;
         stop     = 1'b0;
         for (int s = int'(cur.f.slot); s < FETCH_SLOTS; s++)
         begin
            if (!stop && left > 0)
            begin
               p.raw = base.raw + 32'(4 * s);
               idx   = p.raw[5:2];
               hit   = mirror_valid[idx] && (mirror_tag[idx] == p.raw[31:6]);
               exp_pc.push_back(p);
               exp_ins.push_back(insn_word(p.raw));
               exp_tk.push_back(hit);
               left--;
               // Slot after a taken branch is dropped
               if (hit)
               begin
                  stop = 1'b1;
                  nxt  = mirror_tgt[idx];
               end
            end
         end
         cur = nxt;
      end
   endfunction

   task automatic pc_check(input pc_t exp, input pc_t act);
      if (exp !== act)
      begin
         mismatches++;
         $display("Mismatch %s pc: expected %h, actual %h", test_name, exp.raw, act.raw);
      end
   endtask

   task automatic word_check(input logic [INSN_W-1:0] exp, input logic [INSN_W-1:0] act);
      if (exp !== act)
      begin
         mismatches++;
         $display("Mismatch %s insn: expected %h, actual %h", test_name, exp, act);
      end
   endtask

   task automatic flag_check(input logic exp, input logic act);
      if (exp !== act)
      begin
         mismatches++;
         $display("Mismatch %s taken: expected %0b, actual %0b", test_name, exp, act);
      end
   endtask

   task automatic flush_begin(input logic [PC_W-1:0] addr);
      @(negedge clk);
      pop_en = 1'b0;
      exp_pc.delete();
      exp_ins.delete();
      exp_tk.delete();
      flush_target.raw = addr;
      @(posedge clk);
      #1;
      flush    = 1'b1;
      flush_pc = flush_target;
   endtask

   // One update cycle while flush is held
   task automatic btb_write(input logic [PC_W-1:0] pc, input logic [PC_W-1:0] target,
                            input logic taken);
      btb_upd_valid           = 1'b1;
      btb_upd_pc.raw          = pc;
      btb_upd_target.raw      = target;
      btb_upd_taken           = taken;
      mirror_valid[pc[5:2]]   = taken;
      mirror_tag[pc[5:2]]     = pc[31:6];
      mirror_tgt[pc[5:2]].raw = target;
      @(posedge clk);
      #1;
      btb_upd_valid = 1'b0;
   endtask

   task automatic flush_end(input int count);
      @(posedge clk);
      #1;
      flush = 1'b0;
      expect_stream(flush_target, count);
      @(negedge clk);
      pop_en = 1'b1;
   endtask

   task automatic wait_drained();
      int cycles;
      cycles = 0;
      while (!hung && exp_pc.size() > 0)
      begin
         @(negedge clk);
         cycles++;
         if (cycles > TIMEOUT)
         begin
            failures++;
            hung = 1'b1;
            $display("%s: timed out with %0d instructions never delivered",
                     test_name, exp_pc.size());
         end
      end
   endtask

   // Returns while the nth request is still pending
   task automatic wait_request(input int nth);
      int   cycles;
      int   seen;
      logic prev;
      cycles = 0;
      seen   = 0;
      prev   = 1'b0;
      while (!hung && seen < nth)
      begin
         @(posedge clk);
         #1;
         if (imem_req_valid && !prev)
            seen++;
         prev = imem_req_valid;
         cycles++;
         if (cycles > TIMEOUT)
         begin
            failures++;
            hung = 1'b1;
            $display("%s: timed out waiting for a memory request", test_name);
         end
      end
   endtask

   // Decode side that pops at random and compares what it pops
   initial
   begin : pop_checker
      logic [31:0] seed;
      int          stall;
      int          n;
      seed       = 32'hea;
      stall      = 0;
      id_pop_cnt = '0;
      forever
      begin
         @(posedge clk);
         #1;
         seed = lcg_next(seed);
         if (stall > 0)
            stall--;
         else if (seed[31:28] == 4'h0)
            stall = 10 + int'(seed[27:24]);
         n = 0;
         if (pop_en && stall == 0)
            n = int'(seed[20:19]) % 3;
         if (n > int'(id_valid[0]) + int'(id_valid[1]))
            n = int'(id_valid[0]) + int'(id_valid[1]);
         if (n > exp_pc.size())
            n = exp_pc.size();
         for (int i = 0; i < n; i++)
         begin
            pc_check(exp_pc.pop_front(), id_pc[i]);
            word_check(exp_ins.pop_front(), id_ins[i]);
            flag_check(exp_tk.pop_front(), id_pred_taken[i]);
            checked++;
         end
         id_pop_cnt = slot_cnt_t'(n);
      end
   end

   initial
   begin
      clk            = 1'b0;
      rst_n          = 1'b0;
      flush          = 1'b0;
      flush_pc       = '0;
      btb_upd_valid  = 1'b0;
      btb_upd_pc     = '0;
      btb_upd_target = '0;
      btb_upd_taken  = 1'b0;
      pop_en         = 1'b0;
      hung           = 1'b0;
      mismatches     = 0;
      failures       = 0;
      checked        = 0;
      for (int i = 0; i < BTB_ENTRIES; i++)
         mirror_valid[i] = 1'b0;

      test_name         = "sequential";
      flush_target.raw  = RESET_PC;
      expect_stream(flush_target, 40);
      repeat (10) @(posedge clk);
      #1;
      rst_n  = 1'b1;
      pop_en = 1'b1;
      wait_drained();

      test_name = "unaligned";
      flush_begin(32'h0000_2004);
      flush_end(12);
      wait_drained();

      test_name = "branches";
      flush_begin(32'h0000_3000);
      btb_write(32'h0000_3004, 32'h0000_3100, 1'b1);
      btb_write(32'h0000_3100, 32'h0000_3204, 1'b1);
      btb_write(32'h0000_3208, 32'h0000_3000, 1'b1);
      flush_end(30);
      wait_drained();

      test_name = "clearing";
      flush_begin(32'h0000_3000);
      btb_write(32'h0000_3100, 32'h0000_0000, 1'b0);
      flush_end(30);
      wait_drained();

      test_name = "backpressure";
      flush_begin(32'h0000_3000);
      flush_end(150);
      wait_drained();

      // Each flush lands while a request waits or is outstanding
      test_name = "flush_in_flight";
      for (int r = 0; r < 4; r++)
      begin
         flush_begin(32'h0000_5000 + 32'(r) * 32'h204);
         flush_end(8);
         wait_request(r + 1);
      end
      flush_begin(32'h0000_7000);
      flush_end(24);
      wait_drained();

      $display("Checked %0d instructions, %0d mismatches, %0d other errors",
               checked, mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

// ==== testbench/fetch_mem_model.sv ====
/*
   Instruction memory responder
   Accepts one window request at a time and answers in order after a random
   latency; ready is randomized too, which gives the fetch side back-pressure
*/
`timescale 1ns/1ns

module fetch_mem_model
(
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         imem_req_valid,
   output logic                         imem_req_ready,
   input  logic [fetch_pkg::PC_W-1:0]   imem_req_addr,
   output logic                         imem_rsp_valid,
   output logic [fetch_pkg::WIN_W-1:0]  imem_rsp_data
);
   import fetch_pkg::*;

   logic [31:0]      rng;
   logic             busy;
   int               wait_cnt;
   logic [PC_W-1:0]  addr_q;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Every address holds a distinct word
   function automatic logic [INSN_W-1:0] word_at(input logic [PC_W-1:0] addr);
      return (addr * 32'h9e37_79b1) ^ 32'h1357_9bdf;
   endfunction

   initial
   begin
      imem_req_ready = 1'b0;
      imem_rsp_valid = 1'b0;
      imem_rsp_data  = '0;
      rng            = 32'hea;
      busy           = 1'b0;
      wait_cnt       = 0;
      addr_q         = '0;
      forever
      begin
         @(posedge clk);
         #1;
         imem_rsp_valid = 1'b0;
         if (!rst_n)
         begin
            busy           = 1'b0;
            imem_req_ready = 1'b0;
         end
         else
         begin
            if (busy && wait_cnt == 0)
            begin
               imem_rsp_valid = 1'b1;
               imem_rsp_data  = {word_at(addr_q + 32'd4), word_at(addr_q)};
               busy           = 1'b0;
            end
            else if (busy)
               wait_cnt--;
            rng = lcg_next(rng);
            // Ready drops about one cycle in four
            imem_req_ready = !busy && (rng[17:16] != 2'b00);
            if (imem_req_valid && imem_req_ready)
            begin
               busy     = 1'b1;
               addr_q   = imem_req_addr;
               wait_cnt = int'(rng[26:24]);
            end
         end
      end
   end

endmodule

// ==== rtl/fetch_frontend.sv ====
/*
   Instruction fetch front end
   Ties the fetch controller, the BTB predictor and the instruction queue together
*/
`timescale 1ns/1ns

module fetch_frontend
(
   input  logic                                                      clk,
   input  logic                                                      rst_n,
   input  logic                                                      flush,
   input  fetch_pkg::pc_t                                            flush_pc,
   // Instruction memory
   output logic                                                      imem_req_valid,
   input  logic                                                      imem_req_ready,
   output logic [fetch_pkg::PC_W-1:0]                                imem_req_addr,
   input  logic                                                      imem_rsp_valid,
   input  logic [fetch_pkg::WIN_W-1:0]                               imem_rsp_data,
   // BTB update from execute
   input  logic                                                      btb_upd_valid,
   input  fetch_pkg::pc_t                                            btb_upd_pc,
   input  fetch_pkg::pc_t                                            btb_upd_target,
   input  logic                                                      btb_upd_taken,
   // Decode
   output logic [fetch_pkg::FETCH_SLOTS-1:0]                         id_valid,
   output fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]               id_pc,
   output logic [fetch_pkg::FETCH_SLOTS-1:0][fetch_pkg::INSN_W-1:0]  id_ins,
   output logic [fetch_pkg::FETCH_SLOTS-1:0]                         id_pred_taken,
   input  fetch_pkg::slot_cnt_t                                      id_pop_cnt
);
   import fetch_pkg::*;

   logic                                lookup_en;
   pc_t                                 lookup_pc;
   logic [FETCH_SLOTS-1:0]              pred_hit;
   pc_t [FETCH_SLOTS-1:0]               pred_target;
   logic [IQ_PTR_W:0]                   free_cnt;
   slot_cnt_t                           push_cnt;
   pc_t [FETCH_SLOTS-1:0]               push_pc;
   logic [FETCH_SLOTS-1:0][INSN_W-1:0]  push_ins;
   logic [FETCH_SLOTS-1:0]              push_taken;

   fetch_ctrl u_ctrl
   (
      .clk               (clk),
      .rst_n             (rst_n),
      .flush             (flush),
      .flush_pc          (flush_pc),
      .imem_req_ready    (imem_req_ready),
      .imem_req_valid    (imem_req_valid),
      .imem_req_addr     (imem_req_addr),
      .imem_rsp_valid    (imem_rsp_valid),
      .imem_rsp_data     (imem_rsp_data),
      .lookup_en         (lookup_en),
      .lookup_pc         (lookup_pc),
      .pred_hit          (pred_hit),
      .pred_target       (pred_target),
      .free_cnt          (free_cnt),
      .push_cnt          (push_cnt),
      .push_pc           (push_pc),
      .push_ins          (push_ins),
      .push_taken        (push_taken)
   );

   branch_predictor u_bpu
   (
      .clk               (clk),
      .rst_n             (rst_n),
      .lookup_en         (lookup_en),
      .lookup_pc         (lookup_pc),
      .btb_upd_valid     (btb_upd_valid),
      .btb_upd_pc        (btb_upd_pc),
      .btb_upd_target    (btb_upd_target),
      .btb_upd_taken     (btb_upd_taken),
      .pred_hit          (pred_hit),
      .pred_target       (pred_target)
   );

   insn_queue u_iq
   (
      .clk               (clk),
      .rst_n             (rst_n),
      .flush             (flush),
      .push_cnt          (push_cnt),
      .push_pc           (push_pc),
      .push_ins          (push_ins),
      .push_taken        (push_taken),
      .id_pop_cnt        (id_pop_cnt),
      .free_cnt          (free_cnt),
      .id_valid          (id_valid),
      .id_pc             (id_pc),
      .id_ins            (id_ins),
      .id_pred_taken     (id_pred_taken)
   );

endmodule

// ==== rtl/fetch_ctrl.sv ====
/*
   Fetch controller
   Holds the PC, issues one window request at a time, masks and packs the
   returned slots into the queue and drops responses that predate a flush
*/
`timescale 1ns/1ns

module fetch_ctrl
(
   input  logic                                                      clk,
   input  logic                                                      rst_n,
   input  logic                                                      flush,
   input  fetch_pkg::pc_t                                            flush_pc,
   input  logic                                                      imem_req_ready,
   output logic                                                      imem_req_valid,
   output logic [fetch_pkg::PC_W-1:0]                                imem_req_addr,
   input  logic                                                      imem_rsp_valid,
   input  logic [fetch_pkg::WIN_W-1:0]                               imem_rsp_data,
   output logic                                                      lookup_en,
   output fetch_pkg::pc_t                                            lookup_pc,
   input  logic [fetch_pkg::FETCH_SLOTS-1:0]                         pred_hit,
   input  fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]               pred_target,
   input  logic [fetch_pkg::IQ_PTR_W:0]                              free_cnt,
   output fetch_pkg::slot_cnt_t                                      push_cnt,
   output fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]               push_pc,
   output logic [fetch_pkg::FETCH_SLOTS-1:0][fetch_pkg::INSN_W-1:0]  push_ins,
   output logic [fetch_pkg::FETCH_SLOTS-1:0]                         push_taken
);
   import fetch_pkg::*;

   pc_t                    pc_q;
   pc_t                    pc_nxt;
   pc_t                    req_pc_q;      // fetch address incl. entry slot
   logic                   req_valid_q;
   logic                   outstanding_q;
   logic                   discard_q;
   pc_t                    win_base;
   pc_t [FETCH_SLOTS-1:0]  slot_pc;
   logic                   req_fire;
   logic                   rsp_fire;
   logic                   rsp_take;
   logic                   space_ok;
   logic                   raise;
   logic                   taken_seen;
   pc_t                    taken_tgt;

   assign req_fire = imem_req_valid & imem_req_ready;
   assign rsp_fire = outstanding_q & imem_rsp_valid;
   // Stale responses and those landing on a flush never reach the queue
   assign rsp_take = rsp_fire & ~discard_q & ~flush;

   assign win_base.raw = {req_pc_q.raw[PC_W-1:WIN_OFS_W], {WIN_OFS_W{1'b0}}};

   assign imem_req_valid = req_valid_q;
   assign imem_req_addr  = win_base.raw;

   // BTB is read for the window as it goes out
   assign lookup_en = req_fire;
   assign lookup_pc = win_base;

   always_comb
   begin
      for (int i = 0; i < FETCH_SLOTS; i++)
         slot_pc[i].raw = win_base.raw + PC_W'(i * (INSN_W / 8));
   end

   // Slot mask and packing with entry 0 as the first valid slot
   always_comb
   begin
      slot_cnt_t n;
      n          = '0;
      push_pc    = '0;
      push_ins   = '0;
      push_taken = '0;
      taken_seen = 1'b0;
      taken_tgt  = '0;
      for (int i = 0; i < FETCH_SLOTS; i++)
      begin
         // Skip slots before the entry point and anything after a taken branch
         if (i >= int'(req_pc_q.f.slot) && !taken_seen)
         begin
            push_pc[n[0]]    = slot_pc[i];
            push_ins[n[0]]   = imem_rsp_data[i*INSN_W +: INSN_W];
            push_taken[n[0]] = pred_hit[i];
            if (pred_hit[i])
            begin
               taken_seen = 1'b1;
               taken_tgt  = pred_target[i];
            end
            n = n + 1'b1;
         end
      end
      push_cnt = rsp_take ? n : '0;
   end

   always_comb
   begin
      if (flush)
         pc_nxt = flush_pc;
      else if (rsp_take && taken_seen)
         pc_nxt = taken_tgt;
      else if (rsp_take)
         pc_nxt.raw = win_base.raw + PC_W'(FETCH_SLOTS * (INSN_W / 8));
      else
         pc_nxt = pc_q;
   end

   // Room for a full window once the push now landing is counted
   assign space_ok = flush |
                     (free_cnt >= (IQ_PTR_W+1)'(FETCH_SLOTS) + (IQ_PTR_W+1)'(push_cnt));

   // New request once idle, or right after the previous response
   assign raise = (rsp_fire | (~req_valid_q & ~outstanding_q)) & space_ok;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pc_q.raw      <= RESET_PC;
         req_valid_q   <= 1'b0;
         outstanding_q <= 1'b0;
         discard_q     <= 1'b0;
      end
      else
      begin
         pc_q <= pc_nxt;

         if (raise)
            req_valid_q <= 1'b1;
         else if (req_fire)
            req_valid_q <= 1'b0;

         if (req_fire)
            outstanding_q <= 1'b1;
         else if (rsp_fire)
            outstanding_q <= 1'b0;

         // Whatever is still waiting or in flight belongs to the old stream
         if (flush)
            discard_q <= req_valid_q | (outstanding_q & ~imem_rsp_valid);
         else if (rsp_fire)
            discard_q <= 1'b0;
      end
   end

   always_ff @(posedge clk)
   begin
      if (raise)
         req_pc_q <= pc_nxt;
   end

   // Waiting request keeps its address, even across a flush
   assert property (@(posedge clk) disable iff (!rst_n)
      imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req_addr));

endmodule

// ==== rtl/insn_queue.sv ====
/*
   Instruction queue
   Circular buffer between fetch and decode, up to two pushes and two pops
   per cycle; flush empties it
*/
`timescale 1ns/1ns

module insn_queue
(
   input  logic                                                      clk,
   input  logic                                                      rst_n,
   input  logic                                                      flush,
   input  fetch_pkg::slot_cnt_t                                      push_cnt,
   input  fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]               push_pc,
   input  logic [fetch_pkg::FETCH_SLOTS-1:0][fetch_pkg::INSN_W-1:0]  push_ins,
   input  logic [fetch_pkg::FETCH_SLOTS-1:0]                         push_taken,
   input  fetch_pkg::slot_cnt_t                                      id_pop_cnt,
   output logic [fetch_pkg::IQ_PTR_W:0]                              free_cnt,
   output logic [fetch_pkg::FETCH_SLOTS-1:0]                         id_valid,
   output fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]               id_pc,
   output logic [fetch_pkg::FETCH_SLOTS-1:0][fetch_pkg::INSN_W-1:0]  id_ins,
   output logic [fetch_pkg::FETCH_SLOTS-1:0]                         id_pred_taken
);
   import fetch_pkg::*;

   pc_t                 pc_mem    [IQ_DEPTH];
   logic [INSN_W-1:0]   ins_mem   [IQ_DEPTH];
   logic                taken_mem [IQ_DEPTH];
   logic [IQ_PTR_W-1:0] head;
   logic [IQ_PTR_W-1:0] tail;
   logic [IQ_PTR_W:0]   count;

   assign free_cnt = (IQ_PTR_W+1)'(IQ_DEPTH) - count;

   // Storage pointers wrap at the power-of-two depth
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < FETCH_SLOTS; i++)
      begin
         if (slot_cnt_t'(i) < push_cnt)
         begin
            pc_mem[tail + IQ_PTR_W'(i)]    <= push_pc[i];
            ins_mem[tail + IQ_PTR_W'(i)]   <= push_ins[i];
            taken_mem[tail + IQ_PTR_W'(i)] <= push_taken[i];
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end
      else
      begin
         head  <= head + IQ_PTR_W'(id_pop_cnt);
         tail  <= tail + IQ_PTR_W'(push_cnt);
         count <= count + (IQ_PTR_W+1)'(push_cnt) - (IQ_PTR_W+1)'(id_pop_cnt);
      end
   end

   // Two oldest entries go to decode
   always_comb
   begin
      for (int i = 0; i < FETCH_SLOTS; i++)
      begin
         id_valid[i]      = count > (IQ_PTR_W+1)'(i);
         id_pc[i]         = pc_mem[head + IQ_PTR_W'(i)];
         id_ins[i]        = ins_mem[head + IQ_PTR_W'(i)];
         id_pred_taken[i] = taken_mem[head + IQ_PTR_W'(i)];
      end
   end

   // Fetch sizes its requests so a push always fits
   assert property (@(posedge clk) disable iff (!rst_n)
      (IQ_PTR_W+1)'(push_cnt) <= free_cnt);

   // Decode pops only what it was shown
   assert property (@(posedge clk) disable iff (!rst_n)
      (IQ_PTR_W+1)'(id_pop_cnt) <= count);

endmodule

// ==== rtl/branch_predictor.sv ====
/*
   Branch predictor
   Direct-mapped, tagged BTB; a hit means taken. Two registered lookups
   per window, one update port from execute
*/
`timescale 1ns/1ns

module branch_predictor
(
   input  logic                                         clk,
   input  logic                                         rst_n,
   input  logic                                         lookup_en,
   input  fetch_pkg::pc_t                               lookup_pc,
   input  logic                                         btb_upd_valid,
   input  fetch_pkg::pc_t                               btb_upd_pc,
   input  fetch_pkg::pc_t                               btb_upd_target,
   input  logic                                         btb_upd_taken,
   output logic [fetch_pkg::FETCH_SLOTS-1:0]            pred_hit,
   output fetch_pkg::pc_t [fetch_pkg::FETCH_SLOTS-1:0]  pred_target
);
   import fetch_pkg::*;

   logic [BTB_ENTRIES-1:0]                  btb_valid;
   logic [BTB_TAG_W-1:0]                    btb_tag [BTB_ENTRIES];
   pc_t                                     btb_tgt [BTB_ENTRIES];
   pc_t [FETCH_SLOTS-1:0]                   rd_pc;
   logic [FETCH_SLOTS-1:0][BTB_IDX_W-1:0]   rd_idx;
   logic [BTB_IDX_W-1:0]                    wr_idx;

   // Address bits 5..2
   function automatic logic [BTB_IDX_W-1:0] btb_index(input pc_t pc);
      return {pc.f.win[BTB_IDX_W-2:0], pc.f.slot};
   endfunction

   // Address bits 31..6
   function automatic logic [BTB_TAG_W-1:0] btb_tag_of(input pc_t pc);
      return pc.f.win[PC_W-WIN_OFS_W-1 -: BTB_TAG_W];
   endfunction

   always_comb
   begin
      for (int i = 0; i < FETCH_SLOTS; i++)
      begin
         rd_pc[i].raw = lookup_pc.raw + PC_W'(i * (INSN_W / 8));
         rd_idx[i]    = btb_index(rd_pc[i]);
      end
   end

   assign wr_idx = btb_index(btb_upd_pc);

   // Not-taken update invalidates the entry
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         btb_valid <= '0;
      else if (btb_upd_valid)
         btb_valid[wr_idx] <= btb_upd_taken;
   end

   always_ff @(posedge clk)
   begin
      if (btb_upd_valid && btb_upd_taken)
      begin
         btb_tag[wr_idx] <= btb_tag_of(btb_upd_pc);
         btb_tgt[wr_idx] <= btb_upd_target;
      end
   end

   // Results hold until the next lookup and see old contents on a same-cycle write
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         pred_hit <= '0;
      else if (lookup_en)
         for (int i = 0; i < FETCH_SLOTS; i++)
            pred_hit[i] <= btb_valid[rd_idx[i]] &&
                           (btb_tag[rd_idx[i]] == btb_tag_of(rd_pc[i]));
   end

   always_ff @(posedge clk)
   begin
      if (lookup_en)
         for (int i = 0; i < FETCH_SLOTS; i++)
            pred_target[i] <= btb_tgt[rd_idx[i]];
   end

   // Execute only reports instruction addresses
   assert property (@(posedge clk) disable iff (!rst_n)
      btb_upd_valid |-> btb_upd_pc.f.ofs == 2'b00);

endmodule

// ==== rtl/fetch_pkg.sv ====
/*
   Fetch front end package
   Widths, BTB and queue geometry, the reset vector and the shared PC types
*/
package fetch_pkg;

   localparam int PC_W        = 32;
   localparam int INSN_W      = 32;
   localparam int FETCH_SLOTS = 2;
   localparam int WIN_W       = FETCH_SLOTS * INSN_W;

   // Byte offset bits inside one fetch window
   localparam int WIN_OFS_W   = 3;

   localparam int BTB_ENTRIES = 16;
   localparam int BTB_IDX_W   = 4;
   localparam int BTB_TAG_W   = 26;

   localparam int IQ_DEPTH    = 8;
   localparam int IQ_PTR_W    = 3;

   localparam logic [PC_W-1:0] RESET_PC = 32'h0000_1000;

   // Number of instructions moved in one push or pop, 0..2
   typedef logic [1:0] slot_cnt_t;

   // Raw view for arithmetic, field view for window, slot and byte offset
   typedef union packed
   {
      logic [PC_W-1:0] raw;
      struct packed
      {
         logic [PC_W-WIN_OFS_W-1:0] win;
         logic                      slot;
         logic [1:0]                ofs;
      } f;
   } pc_t;

endpackage
